// ==== hdl/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and instruction widths
`define XLEN        64
`define ILEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5
`define SHAMT_W     6           // RV64 shifts use six bits
`define SP_REG      5'd2        // Stack pointer register, loaded at reset

// Major opcodes, instr[6:0]
`define OPC_OP      7'b0110011  // Register-register ALU
`define OPC_OP_IMM  7'b0010011  // Register-immediate ALU
`define OPC_LUI     7'b0110111
`define OPC_NONE    7'b0000000  // Never a valid RV64I opcode

// funct3, instr[14:12]
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7, instr[31:25]
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // Selects SUB and SRA

`endif

// ==== hdl/core_pkg.sv ====
`include "core_consts.svh"

package core_pkg;

  // Major opcodes the core understands, anything else decodes as other
  typedef enum logic [6:0] {
    OPCODE_OP     = `OPC_OP,
    OPCODE_OP_IMM = `OPC_OP_IMM,
    OPCODE_LUI    = `OPC_LUI,
    OPCODE_OTHER  = `OPC_NONE
  } opcode_e;

  // ALU operations, shared by OP, OP-IMM and LUI
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Decoder output, one per instruction
  typedef struct packed {
    alu_op_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;      // Already sign extended
    logic                   use_imm;  // Second operand from imm instead of rs2
    logic                   illegal;
  } decoded_t;

  // Retired instruction as seen at the core boundary
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       value;    // Zero for illegal instructions
    logic                   illegal;
  } result_t;

endpackage

// ==== hdl/instr_decoder.sv ====
`include "core_consts.svh"

module instr_decoder (
  input  logic               clk,
  input  logic               reset,
  input  logic               instr_valid,
  input  logic [`ILEN-1:0]   instr,
  output logic               dec_valid,
  output core_pkg::decoded_t dec
);

  core_pkg::opcode_e  opc;
  core_pkg::decoded_t dec_next;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [`XLEN-1:0]   imm_i;
  logic [`XLEN-1:0]   imm_u;
  logic               alt;          // funct7 carries the SUB/SRA encoding
  logic               alt_f3;       // funct3 has an alternate form
  logic               shift_op;
  logic               shamt_hi_ok;  // instr[31:26] legal for a 64-bit shift

  // funct3 to ALU op, alt picks SUB or SRA where one exists
  function automatic core_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic sel_alt);
    core_pkg::alu_op_e op;
    case (f3)
      `F3_ADD_SUB: op = sel_alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      `F3_SLL:     op = core_pkg::ALU_SLL;
      `F3_SLT:     op = core_pkg::ALU_SLT;
      `F3_SLTU:    op = core_pkg::ALU_SLTU;
      `F3_XOR:     op = core_pkg::ALU_XOR;
      `F3_SRL_SRA: op = sel_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      `F3_OR:      op = core_pkg::ALU_OR;
      default:     op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};  // LUI value

  assign alt      = funct7 == `F7_ALT;
  assign alt_f3   = funct3 == `F3_ADD_SUB || funct3 == `F3_SRL_SRA;
  assign shift_op = funct3 == `F3_SLL || funct3 == `F3_SRL_SRA;

  // funct7[0] is shamt[5] here, only the upper six bits are checked
  always_comb begin
    if (funct3 == `F3_SLL) begin
      shamt_hi_ok = {funct7[6:1], 1'b0} == `F7_BASE;
    end else begin
      shamt_hi_ok = {funct7[6:1], 1'b0} == `F7_BASE || {funct7[6:1], 1'b0} == `F7_ALT;
    end
  end

  // Opcode classification
  always_comb begin
    case (instr[6:0])
      `OPC_OP:     opc = core_pkg::OPCODE_OP;
      `OPC_OP_IMM: opc = core_pkg::OPCODE_OP_IMM;
      `OPC_LUI:    opc = core_pkg::OPCODE_LUI;
      default:     opc = core_pkg::OPCODE_OTHER;
    endcase
  end

  always_comb begin
    dec_next.op      = core_pkg::ALU_ADD;
    dec_next.rd      = instr[11:7];
    dec_next.rs1     = instr[19:15];
    dec_next.rs2     = instr[24:20];
    dec_next.imm     = imm_i;
    dec_next.use_imm = 1'b0;
    dec_next.illegal = 1'b0;
    case (opc)
      core_pkg::OPCODE_OP: begin
        dec_next.op      = alu_from_f3(funct3, alt);
        // Only ADD/SUB and SRL/SRA accept the alternate funct7
        dec_next.illegal = !(funct7 == `F7_BASE || (alt && alt_f3));
      end
      core_pkg::OPCODE_OP_IMM: begin
        dec_next.use_imm = 1'b1;
        if (shift_op) begin
          dec_next.op      = alu_from_f3(funct3, instr[30]);  // SRAI marker bit
          dec_next.illegal = !shamt_hi_ok;
        end else begin
          dec_next.op = alu_from_f3(funct3, 1'b0);  // No SUBI
        end
      end
      core_pkg::OPCODE_LUI: begin
        dec_next.rs1     = '0;           // x0 + imm
        dec_next.imm     = imm_u;
        dec_next.use_imm = 1'b1;
      end
      default: begin
        dec_next.illegal = 1'b1;  // Unknown opcode
      end
    endcase
  end

  // Strobe is cleared by reset, payload just follows accepted words
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec <= dec_next;
    end
  end

endmodule

// ==== hdl/register_file.sv ====
`include "core_consts.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       stackptr,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wr_en,
  input  logic [`REG_ADDR_W-1:0] wr_addr,
  input  logic [`XLEN-1:0]       wr_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Reset loads the architectural start state
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      regs[`SP_REG] <= stackptr;  // x2 starts at the stack top
    end else if (wr_en && wr_addr != '0) begin
      // x0 writes dropped here
      regs[wr_addr] <= wr_data;
    end
  end

  // Asynchronous read, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/execute_stage.sv ====
`include "core_consts.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dec_valid,
  input  core_pkg::decoded_t     dec,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  output logic                   wr_en,
  output logic [`REG_ADDR_W-1:0] wr_addr,
  output logic [`XLEN-1:0]       wr_data,
  output logic                   result_valid,
  output core_pkg::result_t      result
);

  logic [`XLEN-1:0]    op_b;
  logic [`SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]    alu_result;

  // Operand fetch straight from the decoded fields
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[`SHAMT_W-1:0];  // Upper bits of the shift operand ignored

  always_comb begin
    case (dec.op)
      core_pkg::ALU_ADD:  alu_result = rs1_data + op_b;
      core_pkg::ALU_SUB:  alu_result = rs1_data - op_b;
      core_pkg::ALU_SLL:  alu_result = rs1_data << shamt;
      core_pkg::ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      core_pkg::ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
      core_pkg::ALU_XOR:  alu_result = rs1_data ^ op_b;
      core_pkg::ALU_SRL:  alu_result = rs1_data >> shamt;
      core_pkg::ALU_SRA:  alu_result = $signed(rs1_data) >>> shamt;  // Sign fill
      core_pkg::ALU_OR:   alu_result = rs1_data | op_b;
      core_pkg::ALU_AND:  alu_result = rs1_data & op_b;
      default:            alu_result = '0;
    endcase
  end

  // Write back in the same cycle as the read
  // so a dependent instruction one cycle later sees the new value
  assign wr_en   = dec_valid && !dec.illegal;
  assign wr_addr = dec.rd;         // x0 filtered in the register file
  assign wr_data = alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      result.rd      <= dec.rd;
      result.value   <= dec.illegal ? '0 : alu_result;
      result.illegal <= dec.illegal;
    end
  end

endmodule

// ==== hdl/core_top.sv ====
`include "core_consts.svh"

module core_top (
  input  logic              clk,
  input  logic              reset,
  input  logic [`XLEN-1:0]  stackptr,
  input  logic              instr_valid,
  input  logic [`ILEN-1:0]  instr,
  output logic              result_valid,
  output core_pkg::result_t result
);

  logic                   dec_valid;
  core_pkg::decoded_t     dec;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic                   wr_en;
  logic [`REG_ADDR_W-1:0] wr_addr;
  logic [`XLEN-1:0]       wr_data;

  // Decode, one register stage
  instr_decoder i_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  register_file i_regfile (
    .clk      (clk),
    .reset    (reset),
    .stackptr (stackptr),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  // Execute and write back, second register stage
  execute_stage i_execute (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .dec          (dec),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== test/tb_core.sv ====
`include "core_consts.svh"

module tb_core;

  localparam int LATENCY       = 2;   // Sample edge to observed result strobe
  localparam int DRAIN_TIMEOUT = 20;  // Cycles allowed for outstanding results

  logic              clk = 1'b0;
  logic              reset;
  logic [`XLEN-1:0]  stackptr;
  logic              instr_valid;
  logic [`ILEN-1:0]  instr;
  logic              result_valid;
  core_pkg::result_t result;

  logic [31:0]       rng_state = 32'h6218_3788;
  logic [`XLEN-1:0]  model_regs [`NUM_REGS];  // Register state the core should hold
  core_pkg::result_t exp_q[$];                // Expected results in issue order
  int                sent_q[$];               // Issue cycle of each queued result
  int                cycle = 0;

  core_top i_dut (
    .clk          (clk),
    .reset        (reset),
    .stackptr     (stackptr),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result)
  );

  always #2 clk = ~clk;  // Period 4

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`REG_ADDR_W-1:0] rand_reg();
    logic [31:0] r;
    r = rand32();
    return r[`REG_ADDR_W-1:0];
  endfunction

  // OP-IMM has no SUB form, so the immediate pick skips it
  function automatic core_pkg::alu_op_e pick_op(input logic imm_form);
    int n;
    n = int'(rand32() % (imm_form ? 32'd9 : 32'd10));
    if (imm_form && n >= 1) begin
      n++;
    end
    return core_pkg::alu_op_e'(n[3:0]);
  endfunction

  function automatic logic [2:0] funct3_of(input core_pkg::alu_op_e op);
    case (op)
      core_pkg::ALU_SLL:                  return `F3_SLL;
      core_pkg::ALU_SLT:                  return `F3_SLT;
      core_pkg::ALU_SLTU:                 return `F3_SLTU;
      core_pkg::ALU_XOR:                  return `F3_XOR;
      core_pkg::ALU_SRL, core_pkg::ALU_SRA: return `F3_SRL_SRA;
      core_pkg::ALU_OR:                   return `F3_OR;
      core_pkg::ALU_AND:                  return `F3_AND;
      default:                            return `F3_ADD_SUB;  // ADD and SUB
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(input core_pkg::alu_op_e op);
    return (op == core_pkg::ALU_SUB || op == core_pkg::ALU_SRA) ? `F7_ALT : `F7_BASE;
  endfunction

  // RV64I integer semantics, shift amount from the low six bits of b
  function automatic logic [`XLEN-1:0] alu_model(input core_pkg::alu_op_e op,
                                                 input logic [`XLEN-1:0] a, b);
    logic [5:0]       sh;
    logic [`XLEN-1:0] fill;
    sh   = b[5:0];
    fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;  // Sign bits shifted in by SRA
    case (op)
      core_pkg::ALU_ADD:  return a + b;
      core_pkg::ALU_SUB:  return a - b;
      core_pkg::ALU_SLL:  return a << sh;
      core_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      core_pkg::ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
      core_pkg::ALU_XOR:  return a ^ b;
      core_pkg::ALU_SRL:  return a >> sh;
      core_pkg::ALU_SRA:  return (a >> sh) | fill;
      core_pkg::ALU_OR:   return a | b;
      default:            return a & b;
    endcase
  endfunction

  task automatic write_model(input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] v);
    if (rd != '0) begin
      model_regs[rd] = v;  // x0 stays zero
    end
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_result(input core_pkg::result_t exp, input core_pkg::result_t act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR at time %0t: result expected rd=%0d value=%h illegal=%0b, %s",
                         $time, exp.rd, exp.value, exp.illegal,
                         $sformatf("got rd=%0d value=%h illegal=%0b",
                                   act.rd, act.value, act.illegal)));
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      stop_run($sformatf("ERROR at time %0t: result latency expected %0d cycles, got %0d",
                         $time, exp, act));
    end
  endtask

  // Pops and checks one result per strobe, flags strobes that never came
  task automatic watch_results();
    core_pkg::result_t exp;
    int                sent;
    if (result_valid) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("Result strobe at time %0t with no instruction outstanding",
                           $time));
      end else begin
        exp  = exp_q.pop_front();
        sent = sent_q.pop_front();
        check_latency(LATENCY, cycle - sent);
        check_result(exp, result);
      end
    end else if (sent_q.size() != 0 && cycle - sent_q[0] > LATENCY) begin
      stop_run($sformatf("Result missing at time %0t for the instruction sent in cycle %0d",
                         $time, sent_q[0]));
    end
  endtask

  task automatic advance();
    @(posedge clk);
    #1;  // Outputs settled, inputs change here
    cycle++;
    watch_results();
  endtask

  task automatic idle_cycle();
    advance();
    instr_valid = 1'b0;
    instr       = rand32();  // Junk that must be ignored
  endtask

  task automatic issue(input logic [`ILEN-1:0] word, input core_pkg::result_t exp);
    advance();
    instr_valid = 1'b1;
    instr       = word;
    exp_q.push_back(exp);
    sent_q.push_back(cycle);
  endtask

  task automatic send_op(input core_pkg::alu_op_e op,
                         input logic [`REG_ADDR_W-1:0] rd, rs1, rs2);
    core_pkg::result_t exp;
    exp.rd      = rd;
    exp.value   = alu_model(op, model_regs[rs1], model_regs[rs2]);
    exp.illegal = 1'b0;
    write_model(rd, exp.value);
    issue({funct7_of(op), rs2, rs1, funct3_of(op), rd, `OPC_OP}, exp);
  endtask

  task automatic send_op_imm(input core_pkg::alu_op_e op,
                             input logic [`REG_ADDR_W-1:0] rd, rs1,
                             input logic [11:0] imm);
    core_pkg::result_t  exp;
    logic [11:0]        field;
    logic signed [11:0] simm;
    logic [`XLEN-1:0]   imm64;
    field = imm;
    if (op == core_pkg::ALU_SLL || op == core_pkg::ALU_SRL) begin
      field = {6'b000000, imm[5:0]};  // Six bit shamt
    end else if (op == core_pkg::ALU_SRA) begin
      field = {6'b010000, imm[5:0]};  // SRAI marker in imm[10]
    end
    simm        = field;
    imm64       = simm;  // Signed widening
    exp.rd      = rd;
    exp.value   = alu_model(op, model_regs[rs1], imm64);
    exp.illegal = 1'b0;
    write_model(rd, exp.value);
    issue({field, rs1, funct3_of(op), rd, `OPC_OP_IMM}, exp);
  endtask

  task automatic send_lui(input logic [`REG_ADDR_W-1:0] rd, input logic [19:0] imm);
    core_pkg::result_t  exp;
    logic signed [31:0] upper;
    upper       = {imm, 12'b0};  // Immediate moved up by 12
    exp.rd      = rd;
    exp.value   = upper;         // Widened with its sign
    exp.illegal = 1'b0;
    write_model(rd, exp.value);
    issue({imm, rd, `OPC_LUI}, exp);
  endtask

  task automatic send_illegal(input logic [`ILEN-1:0] word);
    core_pkg::result_t exp;
    exp.rd      = word[11:7];
    exp.value   = '0;  // No write, zero value
    exp.illegal = 1'b1;
    issue(word, exp);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        stop_run($sformatf("Timed out waiting for %0d outstanding results", exp_q.size()));
      end else begin
        idle_cycle();
        waited++;
      end
    end
  endtask

  initial begin
    logic [31:0]            r;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] prev;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    stackptr    = {rand32(), rand32()};
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    model_regs[2] = stackptr;  // x2 comes up as the stack pointer
    for (int i = 0; i < 8; i++) begin
      advance();
    end
    reset = 1'b0;

    // Reset state, ADDI xN, xN, 0 on every register
    for (int i = 0; i < `NUM_REGS; i++) begin
      send_op_imm(core_pkg::ALU_ADD, 5'(i), 5'(i), 12'd0);
    end
    drain();

    // Fill registers with LUI plus ADDI
    for (int i = 1; i < `NUM_REGS; i++) begin
      r = rand32();
      send_lui(5'(i), r[31:12]);
      send_op_imm(core_pkg::ALU_ADD, 5'(i), 5'(i), r[11:0]);
    end
    drain();

    for (int i = 0; i < 300; i++) begin  // Random OP with gaps
      r = rand32();
      if (r[1:0] == 2'b00) begin
        idle_cycle();
      end
      send_op(pick_op(1'b0), rand_reg(), rand_reg(), rand_reg());
    end
    drain();

    for (int i = 0; i < 300; i++) begin  // Random OP-IMM, negative immediates included
      r = rand32();
      if (r[1:0] == 2'b00) begin
        idle_cycle();
      end
      send_op_imm(pick_op(1'b1), rand_reg(), rand_reg(), r[31:20]);
    end
    send_op_imm(core_pkg::ALU_ADD, 5'd0, 5'd5, 12'h7ff);  // Write to x0
    send_op_imm(core_pkg::ALU_ADD, 5'd1, 5'd0, 12'd0);    // x0 must still be zero
    drain();

    for (int i = 0; i < 40; i++) begin
      r = rand32();
      send_lui(rand_reg(), r[19:0]);
    end
    drain();

    // Illegal encodings, each followed by a readback of its rd
    for (int i = 0; i < 40; i++) begin
      r  = rand32();
      rd = rand_reg();
      case (i % 4)
        0: send_illegal({r[31:12], rd, 7'b0000011});  // LOAD, not supported
        1: send_illegal({7'b0000001, r[24:15], r[14:12], rd, `OPC_OP});  // M extension
        2: send_illegal({`F7_ALT, r[24:15], `F3_XOR, rd, `OPC_OP});
        default: send_illegal({6'b100000, r[25:20], r[19:15], `F3_SRL_SRA, rd, `OPC_OP_IMM});
      endcase
      send_op_imm(core_pkg::ALU_ADD, rd, rd, 12'd0);
    end
    drain();

    // Dependent chain, one instruction every cycle
    prev = rand_reg();
    for (int i = 0; i < 100; i++) begin
      r  = rand32();
      rd = rand_reg();
      if (r[0]) begin
        send_op(pick_op(1'b0), rd, prev, rand_reg());
      end else begin
        send_op_imm(pick_op(1'b1), rd, prev, r[31:20]);
      end
      prev = rd;
    end
    drain();

    for (int i = 0; i < 4; i++) begin
      idle_cycle();  // Stray strobes would show up here
    end
    if (exp_q.size() != 0) begin
      stop_run("Results still outstanding at the end of the test");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/core_top.sv
test/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator and run it
# Pass only if the simulation prints the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_core \
    -Mdir obj_dir -o sim_core \
  && ./obj_dir/sim_core 2>&1 | tee /dev/stderr | grep -qF "All tests passed!" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
